// File: rtl/work_cfg_pkg.sv
package work_cfg_pkg;

//======================================================================
// Grid geometry
//======================================================================

// Bit width of one grid coordinate
// Steps and ends use the same width
parameter int WORK_BW = 8;

// Number of grid dimensions
// Dimension 0 is the fastest one in the walk
parameter int VDIM = 2;

endpackage

// File: rtl/block_sched_pkg.sv
package block_sched_pkg;

//======================================================================
// Block scheduling limits
//======================================================================

// Blocks that may be issued but not yet retired
parameter int MAX_PENDING_BLOCK = 3;

// Width that holds 0 up to the pending limit
parameter int PEND_CW = $clog2(MAX_PENDING_BLOCK + 1);

// Worker queue entries
// Must cover the pending limit so an offered offset is never refused
parameter int WORKER_QDEPTH = 4;

// Service time is base plus the masked coordinate sum
parameter int WORKER_DLY_BASE = 2;
parameter int WORKER_DLY_MASK = 3;

endpackage

// File: rtl/nd_stride_adder.sv
`timescale 1ns/100ps

module nd_stride_adder #(
	parameter int WBW = work_cfg_pkg::WORK_BW,
	parameter int DIM = work_cfg_pkg::VDIM
) (
	input  logic [WBW-1:0] i_cur    [DIM],
	input  logic [WBW-1:0] i_stride [DIM],
	input  logic [WBW-1:0] i_end    [DIM],
	output logic [WBW-1:0] o_nxt    [DIM],
	output logic           o_carry
);

//======================================================================
// Odometer step
//======================================================================

// Carry into each dimension
// Dimension 0 always takes the step
logic [DIM:0] carry;

assign carry[0] = 1'b1;

for (genvar d = 0; d < DIM; d++) begin : g_dim
	// One extra bit so a sum near the top of the range cannot alias low
	logic [WBW:0] sum;
	logic         wrap;

	assign sum  = {1'b0, i_cur[d]} + {1'b0, i_stride[d]};
	// Wrap once the sum reaches the end of this dimension
	assign wrap = sum >= {1'b0, i_end[d]};

	// Without a carry in, the coordinate holds
	assign o_nxt[d] = !carry[d] ? i_cur[d] :
		wrap ? '0 : sum[WBW-1:0];

	// Ripple into the next dimension only on a wrap
	assign carry[d+1] = carry[d] && wrap;
end

// Carry out of the top dimension marks the last block
assign o_carry = carry[DIM];

endmodule

// File: rtl/pending_counter.sv
`timescale 1ns/100ps

module pending_counter #(
	parameter int N_PENDING = block_sched_pkg::MAX_PENDING_BLOCK
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_inc,
	input  logic i_dec,
	output logic o_full,
	output logic o_empty
);

// Wide enough to hold the limit itself
localparam int CW = $clog2(N_PENDING + 1);

logic [CW-1:0] cnt;

assign o_full  = cnt == CW'(N_PENDING);
assign o_empty = cnt == '0;

// Issue and retire in one cycle cancel out
always_ff @(posedge i_clk) begin
	if (i_rst) begin
		cnt <= '0;
	end else if (i_inc && !i_dec) begin
		cnt <= cnt + 1'b1;
	end else if (i_dec && !i_inc) begin
		cnt <= cnt - 1'b1;
	end
end

//======================================================================
// Checks
//======================================================================

// Issuer must respect the full flag
a_no_inc_full: assert property (@(posedge i_clk) disable iff (i_rst)
	(i_inc && !i_dec) |-> !o_full);

// Worker never retires a block that was not issued
a_no_dec_empty: assert property (@(posedge i_clk) disable iff (i_rst)
	(i_dec && !i_inc) |-> !o_empty);

endmodule

// File: rtl/block_looper.sv
`timescale 1ns/100ps

module block_looper #(
	parameter int WBW       = work_cfg_pkg::WORK_BW,
	parameter int DIM       = work_cfg_pkg::VDIM,
	parameter int N_PENDING = block_sched_pkg::MAX_PENDING_BLOCK
) (
	input  logic           i_clk,
	input  logic           i_rst,
	input  logic           i_src_rdy,
	output logic           o_src_ack,
	input  logic [WBW-1:0] i_bgrid_step [DIM],
	input  logic [WBW-1:0] i_bgrid_end  [DIM],
	output logic           o_bofs_rdy,
	input  logic           i_bofs_ack,
	output logic [WBW-1:0] o_bofs       [DIM],
	input  logic           i_blkdone_dval
);

//======================================================================
// Internal
//======================================================================

// Phases of one command
localparam logic [1:0] S_IDLE  = 2'd0;
localparam logic [1:0] S_ISSUE = 2'd1;
localparam logic [1:0] S_DRAIN = 2'd2;

logic [1:0]     state;
logic [WBW-1:0] step_q   [DIM];
logic [WBW-1:0] end_q    [DIM];
logic [WBW-1:0] bofs_nxt [DIM];
logic           last_block;
logic           blk_full;
logic           blk_empty;
logic           bofs_xfer;
logic           cmd_take;
logic [DIM-1:0] step_nz;

// Command accepted only while idle
assign cmd_take = (state == S_IDLE) && i_src_rdy;

// Offer offsets until the pending limit is hit
// Rdy cannot fall without a transfer since the count only drops meanwhile
assign o_bofs_rdy = (state == S_ISSUE) && !blk_full;
assign bofs_xfer  = o_bofs_rdy && i_bofs_ack;

// Single-cycle ack once every issued block has come back
assign o_src_ack = (state == S_DRAIN) && blk_empty;

//======================================================================
// Submodules
//======================================================================

nd_stride_adder #(
	.WBW (WBW),
	.DIM (DIM)
) u_adder (
	.i_cur    (o_bofs),
	.i_stride (step_q),
	.i_end    (end_q),
	.o_nxt    (bofs_nxt),
	.o_carry  (last_block)
);

pending_counter #(
	.N_PENDING (N_PENDING)
) u_pending (
	.i_clk   (i_clk),
	.i_rst   (i_rst),
	.i_inc   (bofs_xfer),
	.i_dec   (i_blkdone_dval),
	.o_full  (blk_full),
	.o_empty (blk_empty)
);

//======================================================================
// Sequential
//======================================================================

always_ff @(posedge i_clk) begin
	if (i_rst) begin
		state <= S_IDLE;
	end else begin
		case (state)
			S_IDLE:  if (i_src_rdy) state <= S_ISSUE;
			// Carry out on a transfer means that was the final block
			S_ISSUE: if (bofs_xfer && last_block) state <= S_DRAIN;
			S_DRAIN: if (blk_empty) state <= S_IDLE;
			default: state <= S_IDLE;
		endcase
	end
end

// Grid shape held for the whole command
always_ff @(posedge i_clk) begin
	if (cmd_take) begin
		step_q <= i_bgrid_step;
		end_q  <= i_bgrid_end;
	end
end

// Walk starts from zero and returns there on ack
always_ff @(posedge i_clk) begin
	if (i_rst || o_src_ack) begin
		for (int i = 0; i < DIM; i++) begin
			o_bofs[i] <= '0;
		end
	end else if (bofs_xfer && !last_block) begin
		o_bofs <= bofs_nxt;
	end
end

//======================================================================
// Checks
//======================================================================

for (genvar d = 0; d < DIM; d++) begin : g_step_nz
	assign step_nz[d] = |step_q[d];
end

// A zero step would stall the odometer forever
a_step_nonzero: assert property (@(posedge i_clk) disable iff (i_rst)
	(state != S_IDLE) |-> &step_nz);

endmodule

// File: rtl/block_worker.sv
`timescale 1ns/100ps

module block_worker #(
	parameter int WBW = work_cfg_pkg::WORK_BW,
	parameter int DIM = work_cfg_pkg::VDIM
) (
	input  logic           i_clk,
	input  logic           i_rst,
	input  logic           i_bofs_rdy,
	output logic           o_bofs_ack,
	input  logic [WBW-1:0] i_bofs     [DIM],
	output logic           o_blkdone_dval,
	output logic [WBW-1:0] o_done_ofs [DIM]
);

localparam int QD = block_sched_pkg::WORKER_QDEPTH;
localparam int AW = (QD > 1) ? $clog2(QD) : 1;
localparam int DW = $clog2(block_sched_pkg::WORKER_DLY_BASE +
	block_sched_pkg::WORKER_DLY_MASK + 1);

//======================================================================
// Queue
//======================================================================

logic [WBW-1:0] q_mem [QD][DIM];
logic [AW-1:0]  wr_ptr;
logic [AW-1:0]  rd_ptr;
logic [AW:0]    q_cnt;
logic           push;
logic           pop;
logic           busy;
logic [DW-1:0]  dly_cnt;
logic [DW-1:0]  head_dly;
logic [WBW-1:0] head_sum;

// Take an offset whenever there is space
assign o_bofs_ack = q_cnt != (AW+1)'(QD);
assign push       = i_bofs_rdy && o_bofs_ack;
// Head retires when its countdown has run out
assign pop        = busy && (dly_cnt == '0);

always_ff @(posedge i_clk) begin
	if (push) begin
		q_mem[wr_ptr] <= i_bofs;
	end
end

always_ff @(posedge i_clk) begin
	if (i_rst) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		q_cnt  <= '0;
	end else begin
		if (push) wr_ptr <= (wr_ptr == AW'(QD - 1)) ? '0 : wr_ptr + 1'b1;
		if (pop)  rd_ptr <= (rd_ptr == AW'(QD - 1)) ? '0 : rd_ptr + 1'b1;
		if (push && !pop) begin
			q_cnt <= q_cnt + 1'b1;
		end else if (pop && !push) begin
			q_cnt <= q_cnt - 1'b1;
		end
	end
end

//======================================================================
// Service delay
//======================================================================

// Coordinate sum of the head entry
always_comb begin
	head_sum = '0;
	for (int d = 0; d < DIM; d++) begin
		head_sum = head_sum + q_mem[rd_ptr][d];
	end
end

assign head_dly = DW'(block_sched_pkg::WORKER_DLY_BASE) +
	DW'(head_sum & WBW'(block_sched_pkg::WORKER_DLY_MASK));

// Countdown is loaded when an entry first reaches the head
always_ff @(posedge i_clk) begin
	if (i_rst) begin
		busy    <= 1'b0;
		dly_cnt <= '0;
	end else if (!busy && q_cnt != '0) begin
		busy    <= 1'b1;
		dly_cnt <= head_dly;
	end else if (pop) begin
		busy    <= 1'b0;
	end else if (busy) begin
		dly_cnt <= dly_cnt - 1'b1;
	end
end

// One done pulse per retired block in issue order
always_ff @(posedge i_clk) begin
	if (i_rst) begin
		o_blkdone_dval <= 1'b0;
		for (int i = 0; i < DIM; i++) begin
			o_done_ofs[i] <= '0;
		end
	end else begin
		o_blkdone_dval <= pop;
		if (pop) o_done_ofs <= q_mem[rd_ptr];
	end
end

// Pending limit upstream must keep offers within the queue depth
a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rst)
	i_bofs_rdy |-> q_cnt != (AW+1)'(QD));

endmodule

// File: rtl/block_dispatch_top.sv
`timescale 1ns/100ps

module block_dispatch_top #(
	parameter int WBW       = work_cfg_pkg::WORK_BW,
	parameter int DIM       = work_cfg_pkg::VDIM,
	parameter int N_PENDING = block_sched_pkg::MAX_PENDING_BLOCK
) (
	input  logic           i_clk,
	input  logic           i_rst,
	input  logic           i_src_rdy,
	output logic           o_src_ack,
	input  logic [WBW-1:0] i_bgrid_step [DIM],
	input  logic [WBW-1:0] i_bgrid_end  [DIM],
	output logic           o_bofs_valid,
	output logic [WBW-1:0] o_bofs       [DIM],
	output logic           o_done_valid,
	output logic [WBW-1:0] o_done_ofs   [DIM]
);

//======================================================================
// Looper to worker wires
//======================================================================

logic bofs_rdy;
logic bofs_ack;
logic blkdone_dval;

// Monitor copies of each transfer and each retirement
assign o_bofs_valid = bofs_rdy && bofs_ack;
assign o_done_valid = blkdone_dval;

block_looper #(
	.WBW       (WBW),
	.DIM       (DIM),
	.N_PENDING (N_PENDING)
) u_looper (
	.i_clk          (i_clk),
	.i_rst          (i_rst),
	.i_src_rdy      (i_src_rdy),
	.o_src_ack      (o_src_ack),
	.i_bgrid_step   (i_bgrid_step),
	.i_bgrid_end    (i_bgrid_end),
	.o_bofs_rdy     (bofs_rdy),
	.i_bofs_ack     (bofs_ack),
	.o_bofs         (o_bofs),
	.i_blkdone_dval (blkdone_dval)
);

// Stand-in for the compute units
block_worker #(
	.WBW (WBW),
	.DIM (DIM)
) u_worker (
	.i_clk          (i_clk),
	.i_rst          (i_rst),
	.i_bofs_rdy     (bofs_rdy),
	.o_bofs_ack     (bofs_ack),
	.i_bofs         (o_bofs),
	.o_blkdone_dval (blkdone_dval),
	.o_done_ofs     (o_done_ofs)
);

endmodule

// File: sim/block_dispatch_tb.sv
`timescale 1ns/100ps

module block_dispatch_tb;

localparam int WBW        = work_cfg_pkg::WORK_BW;
localparam int DIM        = work_cfg_pkg::VDIM;
localparam int N_PENDING  = block_sched_pkg::MAX_PENDING_BLOCK;
// Worst case cycles per block covering load, longest countdown and pop
localparam int BLK_CYCLES = block_sched_pkg::WORKER_DLY_BASE +
	block_sched_pkg::WORKER_DLY_MASK + 2;

logic           i_clk;
logic           i_rst;
logic           i_src_rdy;
logic           o_src_ack;
logic [WBW-1:0] i_bgrid_step [DIM];
logic [WBW-1:0] i_bgrid_end  [DIM];
logic           o_bofs_valid;
logic [WBW-1:0] o_bofs       [DIM];
logic           o_done_valid;
logic [WBW-1:0] o_done_ofs   [DIM];

// Command table with steps and ends flattened per dimension
int cmd_step[$];
int cmd_end[$];
int cmd_cnt[$];
int cmd_sum[$];

// Reference odometer and per command tallies
int          cur_ofs  [DIM];
int          cur_step [DIM];
int          cur_end  [DIM];
bit          cmd_active;
bit          model_done;
int          ofs_seen;
int          done_seen;
int          ack_seen;
logic [15:0] csum;
int          issued[$];
string       test_name;
int          errors;
int          limit_cycles = 0;
logic [31:0] rng_state;

initial i_clk = 1'b0;
always #20 i_clk = ~i_clk;

block_dispatch_top #(
	.WBW       (WBW),
	.DIM       (DIM),
	.N_PENDING (N_PENDING)
) block_dispatch_top_i (
	.i_clk        (i_clk),
	.i_rst        (i_rst),
	.i_src_rdy    (i_src_rdy),
	.o_src_ack    (o_src_ack),
	.i_bgrid_step (i_bgrid_step),
	.i_bgrid_end  (i_bgrid_end),
	.o_bofs_valid (o_bofs_valid),
	.o_bofs       (o_bofs),
	.o_done_valid (o_done_valid),
	.o_done_ofs   (o_done_ofs)
);

//======================================================================
// Helpers
//======================================================================

function automatic logic [31:0] xorshift32(logic [31:0] s);
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

task automatic check_value(input string name, input int expected, input int actual);
	if (expected !== actual) begin
		errors++;
		$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
	end
endtask

task automatic note_error(input string msg);
	errors++;
	$display("ERROR %s", msg);
endtask

// Step the reference odometer with dim 0 fastest
// A dimension wraps at its end and carries up
task automatic advance_model();
	bit carry;
	carry = 1'b1;
	for (int d = 0; d < DIM; d++) begin
		if (carry) begin
			if (cur_ofs[d] + cur_step[d] >= cur_end[d]) begin
				cur_ofs[d] = 0;
			end else begin
				cur_ofs[d] = cur_ofs[d] + cur_step[d];
				carry = 1'b0;
			end
		end
	end
	if (carry) model_done = 1'b1;
endtask

//======================================================================
// Monitor sampled mid cycle
//======================================================================

always @(negedge i_clk) begin : monitor
	int key;
	int exp_key;
	if (!i_rst) begin
		if (o_bofs_valid) begin
			if (!cmd_active || model_done) begin
				note_error("offset transferred while no block of a command was due");
			end else begin
				key = 0;
				for (int d = 0; d < DIM; d++) begin
					check_value($sformatf("%s offset dim%0d", test_name, d),
						cur_ofs[d], int'(o_bofs[d]));
					csum = csum + 16'((d + 1) * int'(o_bofs[d]));
					key = key | (int'(o_bofs[d]) << (d * WBW));
				end
				issued.push_back(key);
				ofs_seen++;
				advance_model();
			end
		end
		if (o_done_valid) begin
			done_seen++;
			if (issued.size() == 0) begin
				note_error("done pulse arrived with no block outstanding");
			end else begin
				exp_key = issued.pop_front();
				key = 0;
				for (int d = 0; d < DIM; d++) begin
					key = key | (int'(o_done_ofs[d]) << (d * WBW));
				end
				check_value($sformatf("%s done order", test_name), exp_key, key);
			end
		end
		// Outstanding blocks must stay within the pending limit
		if (ofs_seen - done_seen > N_PENDING) begin
			note_error($sformatf("%s has more than %0d blocks outstanding",
				test_name, N_PENDING));
		end
		if (o_src_ack) begin
			ack_seen++;
			if (!cmd_active) note_error("command ack seen with no command pending");
			check_value($sformatf("%s dones at ack", test_name), ofs_seen, done_seen);
			cmd_active = 1'b0;
		end
	end
end

//======================================================================
// Watchdog
//======================================================================

initial begin : watchdog
	wait (limit_cycles > 0);
	repeat (limit_cycles) @(posedge i_clk);
	$display("Timeout: run did not finish all commands within %0d cycles", limit_cycles);
	$display("Simulation finished: FAIL");
	$finish;
end

//======================================================================
// Stimulus
//======================================================================

initial begin : main
	int    fd;
	int    n;
	string line;
	int    s0;
	int    s1;
	int    e0;
	int    e1;
	int    cnt;
	int    sum;
	int    prod;
	int    gap;
	int    errs_before;
	int    passed;
	int    failed;
	i_rst      = 1'b1;
	i_src_rdy  = 1'b0;
	for (int d = 0; d < DIM; d++) begin
		i_bgrid_step[d] = '0;
		i_bgrid_end[d]  = '0;
	end
	cmd_active = 1'b0;
	model_done = 1'b0;
	ofs_seen   = 0;
	done_seen  = 0;
	ack_seen   = 0;
	csum       = '0;
	errors     = 0;
	passed     = 0;
	failed     = 0;
	test_name  = "reset";
	rng_state  = 32'h8094_cf22;

	// Columns of the data file assume a two dimensional grid
	if (DIM != 2) note_error("data file columns assume two grid dimensions");
	fd = $fopen("sim/dispatch_input.txt", "r");
	if (fd == 0) note_error("could not open sim/dispatch_input.txt");
	while (fd != 0 && !$feof(fd)) begin
		line = "";
		n = $fgets(line, fd);
		if (n > 0 && line.len() > 0 && line[0] != "#") begin
			n = $sscanf(line, "%d %d %d %d %d %d", s0, s1, e0, e1, cnt, sum);
			if (n == 6) begin
				cmd_step.push_back(s0);
				cmd_step.push_back(s1);
				cmd_end.push_back(e0);
				cmd_end.push_back(e1);
				cmd_cnt.push_back(cnt);
				cmd_sum.push_back(sum);
			end else if (n > 0) begin
				note_error($sformatf("malformed line in data file: %s", line));
			end
		end
	end
	if (fd != 0) $fclose(fd);
	if (cmd_cnt.size() == 0) note_error("no commands were read from the data file");

	// Budget per block plus fill, drain and idle gap per command
	limit_cycles = 20;
	foreach (cmd_cnt[i]) limit_cycles += cmd_cnt[i] * BLK_CYCLES + 16;

	repeat (5) @(posedge i_clk);
	#2;
	i_rst = 1'b0;

	for (int c = 0; c < cmd_cnt.size(); c++) begin
		test_name   = $sformatf("cmd%0d", c + 1);
		errs_before = errors;
		rng_state   = xorshift32(rng_state);
		gap         = 1 + int'(rng_state % 4);
		prod        = 1;
		for (int d = 0; d < DIM; d++) begin
			cur_step[d] = cmd_step[c*DIM + d];
			cur_end[d]  = cmd_end[c*DIM + d];
			cur_ofs[d]  = 0;
			prod = prod * ((cur_end[d] + cur_step[d] - 1) / cur_step[d]);
		end
		check_value($sformatf("%s count rule", test_name), prod, cmd_cnt[c]);
		ofs_seen   = 0;
		done_seen  = 0;
		ack_seen   = 0;
		csum       = '0;
		model_done = 1'b0;

		// Request held with its grid until ack
		for (int d = 0; d < DIM; d++) begin
			i_bgrid_step[d] = WBW'(cur_step[d]);
			i_bgrid_end[d]  = WBW'(cur_end[d]);
		end
		i_src_rdy  = 1'b1;
		cmd_active = 1'b1;
		do @(negedge i_clk); while (o_src_ack !== 1'b1);
		@(posedge i_clk);
		#2;
		i_src_rdy = 1'b0;

		// Idle gap also catches stray offsets or a second ack
		repeat (gap) @(posedge i_clk);
		#2;
		check_value($sformatf("%s acks", test_name), 1, ack_seen);
		check_value($sformatf("%s blocks", test_name), cmd_cnt[c], ofs_seen);
		check_value($sformatf("%s dones", test_name), cmd_cnt[c], done_seen);
		check_value($sformatf("%s checksum", test_name), cmd_sum[c], int'(csum));
		if (errors == errs_before) passed++;
		else failed++;
		$display("%s %s: %0d blocks, checksum %0d", test_name,
			(errors == errs_before) ? "passed" : "failed", ofs_seen, csum);
	end

	$display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
	if (errors == 0) begin
		$display("Simulation finished: PASS");
	end else begin
		$display("Simulation finished: FAIL");
	end
	$finish;
end

endmodule

// File: sim/dispatch_input.txt
# step0 step1 end0 end1 blocks checksum
# checksum: 16-bit wrapping sum of coord0 + 2*coord1 over all blocks
1 1 4 3 12 42
3 2 10 5 12 102
5 7 5 7 1 0
9 20 4 6 1 0
1 1 1 1 1 0
2 1 7 1 4 12
1 4 1 13 4 48
7 5 30 17 20 580
64 100 250 255 12 3552
1 1 5 5 25 150
3 3 3 8 3 18
50 60 255 200 24 7320
2 1 3 2 4 8
4 1 16 3 12 96
1 2 2 9 10 85
10 10 9 9 1 0
6 1 13 1 3 18
128 128 255 255 4 768
1 3 3 3 3 3
5 1 11 4 12 96

// File: filelist.f
rtl/work_cfg_pkg.sv
rtl/block_sched_pkg.sv
rtl/nd_stride_adder.sv
rtl/pending_counter.sv
rtl/block_looper.sv
rtl/block_worker.sv
rtl/block_dispatch_top.sv
sim/block_dispatch_tb.sv
